//--- include/adapter_defs.svh
// Adapter width and count definitions
`ifndef ADAPTER_DEFS_SVH
`define ADAPTER_DEFS_SVH

// bus word and address widths
`define ADP_WORD_W 32
`define ADP_ADDR_W 32
`define ADP_ID_W 4

// cache line geometry
`define ADP_LINE_WORDS 4
`define ADP_LINE_OFS_W 4

// byte offset inside one bus word
`define ADP_WORD_OFS_W 2

`endif

//--- design/bus_pkg.sv
// AXI side types
`default_nettype none

`include "adapter_defs.svh"

package bus_pkg;

  // ----------------------------------------
  // address and id
  // ----------------------------------------
  typedef logic [`ADP_ADDR_W-1:0] addr_t;
  typedef logic [`ADP_ID_W-1:0]   id_t;

  // one data beat and its byte enables
  typedef logic [`ADP_WORD_W-1:0]   word_t;
  typedef logic [`ADP_WORD_W/8-1:0] strb_t;

  // burst length is beats minus one
  // size is log2 of bytes per beat
  typedef logic [7:0] len_t;
  typedef logic [2:0] size_t;

endpackage

`default_nettype wire

//--- design/line_pkg.sv
// Cache line side types and controller states
`default_nettype none

`include "adapter_defs.svh"

package line_pkg;

  // word index inside a line
  typedef logic [$clog2(`ADP_LINE_WORDS)-1:0] beat_idx_t;

  // whole line and its byte enables
  typedef bus_pkg::word_t [`ADP_LINE_WORDS-1:0] line_t;
  typedef bus_pkg::strb_t [`ADP_LINE_WORDS-1:0] line_strb_t;

  // request opcode
  typedef enum logic {
    REQ_SINGLE,
    REQ_LINE
  } req_kind_e;

  // ----------------------------------------
  // FSM states
  // ----------------------------------------
  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_BUSY,
    CTRL_RESP
  } ctrl_state_e;

  typedef enum logic [1:0] {
    WR_IDLE,
    WR_SEND,
    WR_RESP
  } wr_state_e;

  typedef enum logic [1:0] {
    RD_IDLE,
    RD_ADDR,
    RD_DATA
  } rd_state_e;

endpackage

`default_nettype wire

//--- design/line_buf_if.sv
// Line buffer access interface
`default_nettype none

interface line_buf_if;

  // whole-line load from the controller
  logic                   load_en;
  line_pkg::line_t        load_line;
  line_pkg::line_strb_t   load_strb;
  line_pkg::line_t        line;

  // word read port for the write path
  line_pkg::beat_idx_t    rd_idx;
  bus_pkg::word_t         rd_word;
  bus_pkg::strb_t         rd_strb;

  // word write port for the read path
  logic                   wr_en;
  line_pkg::beat_idx_t    wr_idx;
  bus_pkg::word_t         wr_word;

  modport buf_mp (
    input  load_en, load_line, load_strb, rd_idx, wr_en, wr_idx, wr_word,
    output line, rd_word, rd_strb
  );

  modport ctrl_mp (output load_en, load_line, load_strb, input line);

  modport issue_mp (output rd_idx, input rd_word, rd_strb);

  modport collect_mp (output wr_en, wr_idx, wr_word);

endinterface

`default_nettype wire

//--- design/burst_cmd_if.sv
// Burst command and completion interface
`default_nettype none

interface burst_cmd_if;

  // start pulses
  logic                wr_start;
  logic                rd_start;

  // command fields stay stable from start until done
  bus_pkg::addr_t      addr;
  bus_pkg::len_t       len;
  bus_pkg::size_t      size;
  bus_pkg::id_t        id;
  line_pkg::beat_idx_t crit_idx;

  // completion from the write engine
  logic                wr_done;
  bus_pkg::id_t        done_id;

  // completion from the read engine
  logic                rd_done;
  bus_pkg::id_t        rd_id;

  modport ctrl_mp (
    output wr_start, rd_start, addr, len, size, id, crit_idx,
    input  wr_done, done_id, rd_done, rd_id
  );

  modport wr_mp (
    input  wr_start, addr, len, size, id,
    output wr_done, done_id
  );

  modport rd_mp (
    input  rd_start, addr, len, size, id, crit_idx,
    output rd_done, rd_id
  );

endinterface

`default_nettype wire

//--- design/line_buffer.sv
// Cache line buffer
`default_nettype none

module line_buffer (
  input  wire         clk_i,
  input  wire         rst_ni,
  line_buf_if.buf_mp  bus
);

  line_pkg::line_t      line_q;
  line_pkg::line_strb_t strb_q;

  // whole-line load wins over a single word write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      line_q <= '0;
      strb_q <= '0;
    end else if (bus.load_en) begin
      line_q <= bus.load_line;
      strb_q <= bus.load_strb;
    end else if (bus.wr_en) begin
      line_q[bus.wr_idx] <= bus.wr_word;
    end
  end

  // ----------------------------------------
  // read side
  // ----------------------------------------
  assign bus.line    = line_q;
  assign bus.rd_word = line_q[bus.rd_idx];
  assign bus.rd_strb = strb_q[bus.rd_idx];

endmodule

`default_nettype wire

//--- design/request_ctrl.sv
// Cache request controller
`default_nettype none

`include "adapter_defs.svh"

module request_ctrl (
  input  wire                        clk_i,
  input  wire                        rst_ni,
  input  wire                        req_i,
  input  wire                        we_i,
  input  line_pkg::req_kind_e        line_i,
  input  bus_pkg::addr_t             addr_i,
  input  bus_pkg::size_t             size_i,
  input  bus_pkg::id_t               id_i,
  input  line_pkg::line_t            wdata_i,
  input  line_pkg::line_strb_t       be_i,
  output logic                       gnt_o,
  output logic                       valid_o,
  output line_pkg::line_t            rdata_o,
  output bus_pkg::id_t               id_o,
  line_buf_if.ctrl_mp                lbuf,
  burst_cmd_if.ctrl_mp               cmd
);

  line_pkg::ctrl_state_e state_q;
  logic                  wr_start_q;
  logic                  rd_start_q;
  bus_pkg::id_t          resp_id_q;
  logic                  is_line;

  // command fields
  bus_pkg::addr_t        addr_q;
  bus_pkg::len_t         len_q;
  bus_pkg::size_t        size_q;
  bus_pkg::id_t          id_q;
  line_pkg::beat_idx_t   crit_q;

  assign is_line = (line_i == line_pkg::REQ_LINE);
  assign gnt_o   = req_i && (state_q == line_pkg::CTRL_IDLE);

  // write data goes into the buffer on the grant
  assign lbuf.load_en   = gnt_o && we_i;
  assign lbuf.load_line = wdata_i;
  assign lbuf.load_strb = be_i;

  // ----------------------------------------
  // sequencing
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= line_pkg::CTRL_IDLE;
      wr_start_q <= 1'b0;
      rd_start_q <= 1'b0;
      resp_id_q  <= '0;
    end else begin
      wr_start_q <= gnt_o && we_i;
      rd_start_q <= gnt_o && !we_i;
      case (state_q)
        line_pkg::CTRL_IDLE: begin
          if (req_i) begin
            state_q <= line_pkg::CTRL_BUSY;
          end
        end
        line_pkg::CTRL_BUSY: begin
          if (cmd.wr_done || cmd.rd_done) begin
            state_q   <= line_pkg::CTRL_RESP;
            resp_id_q <= cmd.wr_done ? cmd.done_id : cmd.rd_id;
          end
        end
        default: state_q <= line_pkg::CTRL_IDLE;
      endcase
    end
  end

  // line requests start at the line base with word sized beats
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      id_q   <= id_i;
      crit_q <= addr_i[`ADP_LINE_OFS_W-1:`ADP_WORD_OFS_W];
      if (is_line) begin
        addr_q <= {addr_i[`ADP_ADDR_W-1:`ADP_LINE_OFS_W], {`ADP_LINE_OFS_W{1'b0}}};
        len_q  <= bus_pkg::len_t'(`ADP_LINE_WORDS - 1);
        size_q <= bus_pkg::size_t'(`ADP_WORD_OFS_W);
      end else begin
        addr_q <= addr_i;
        len_q  <= '0;
        size_q <= size_i;
      end
    end
  end

  assign cmd.wr_start = wr_start_q;
  assign cmd.rd_start = rd_start_q;
  assign cmd.addr     = addr_q;
  assign cmd.len      = len_q;
  assign cmd.size     = size_q;
  assign cmd.id       = id_q;
  assign cmd.crit_idx = crit_q;

  // results
  assign valid_o = (state_q == line_pkg::CTRL_RESP);
  assign rdata_o = lbuf.line;
  assign id_o    = resp_id_q;

endmodule

`default_nettype wire

//--- design/write_beat_issuer.sv
// AXI write burst engine
`default_nettype none

module write_beat_issuer (
  input  wire            clk_i,
  input  wire            rst_ni,
  burst_cmd_if.wr_mp     cmd,
  line_buf_if.issue_mp   lbuf,
  output logic           aw_valid_o,
  input  wire            aw_ready_i,
  output bus_pkg::addr_t aw_addr_o,
  output bus_pkg::len_t  aw_len_o,
  output bus_pkg::size_t aw_size_o,
  output bus_pkg::id_t   aw_id_o,
  output logic           w_valid_o,
  input  wire            w_ready_i,
  output bus_pkg::word_t w_data_o,
  output bus_pkg::strb_t w_strb_o,
  output logic           w_last_o,
  input  wire            b_valid_i,
  output logic           b_ready_o,
  input  bus_pkg::id_t   b_id_i
);

  line_pkg::wr_state_e state_q;
  logic                aw_done_q;
  logic                w_done_q;
  bus_pkg::len_t       beat_q;
  logic                aw_hs;
  logic                w_hs;
  logic                aw_fin;
  logic                w_fin;

  // AW and W run independently while sending
  assign aw_valid_o = (state_q == line_pkg::WR_SEND) && !aw_done_q;
  assign w_valid_o  = (state_q == line_pkg::WR_SEND) && !w_done_q;
  assign b_ready_o  = (state_q == line_pkg::WR_RESP);

  assign aw_hs  = aw_valid_o && aw_ready_i;
  assign w_hs   = w_valid_o && w_ready_i;
  assign aw_fin = aw_done_q || aw_hs;
  assign w_fin  = w_done_q || (w_hs && w_last_o);

  // ----------------------------------------
  // beat sequencing
  // ----------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= line_pkg::WR_IDLE;
      aw_done_q <= 1'b0;
      w_done_q  <= 1'b0;
      beat_q    <= '0;
    end else begin
      case (state_q)
        line_pkg::WR_IDLE: begin
          if (cmd.wr_start) begin
            state_q   <= line_pkg::WR_SEND;
            aw_done_q <= 1'b0;
            w_done_q  <= 1'b0;
            beat_q    <= '0;
          end
        end
        line_pkg::WR_SEND: begin
          if (aw_hs) begin
            aw_done_q <= 1'b1;
          end
          if (w_hs) begin
            if (w_last_o) begin
              w_done_q <= 1'b1;
            end else begin
              beat_q <= beat_q + 1'b1;
            end
          end
          if (aw_fin && w_fin) begin
            state_q <= line_pkg::WR_RESP;
          end
        end
        line_pkg::WR_RESP: begin
          if (b_valid_i) begin
            state_q <= line_pkg::WR_IDLE;
          end
        end
        default: state_q <= line_pkg::WR_IDLE;
      endcase
    end
  end

  // address channel fields come straight from the command
  assign aw_addr_o = cmd.addr;
  assign aw_len_o  = cmd.len;
  assign aw_size_o = cmd.size;
  assign aw_id_o   = cmd.id;

  // beat counter picks the buffer word
  assign lbuf.rd_idx = line_pkg::beat_idx_t'(beat_q);
  assign w_data_o    = lbuf.rd_word;
  assign w_strb_o    = lbuf.rd_strb;
  assign w_last_o    = (beat_q == cmd.len);

  assign cmd.wr_done = b_ready_o && b_valid_i;
  assign cmd.done_id = b_id_i;

endmodule

`default_nettype wire

//--- design/read_beat_collector.sv
// AXI read burst engine
`default_nettype none

module read_beat_collector (
  input  wire            clk_i,
  input  wire            rst_ni,
  burst_cmd_if.rd_mp     cmd,
  line_buf_if.collect_mp lbuf,
  output logic           ar_valid_o,
  input  wire            ar_ready_i,
  output bus_pkg::addr_t ar_addr_o,
  output bus_pkg::len_t  ar_len_o,
  output bus_pkg::size_t ar_size_o,
  output bus_pkg::id_t   ar_id_o,
  input  wire            r_valid_i,
  output logic           r_ready_o,
  input  bus_pkg::word_t r_data_i,
  input  bus_pkg::id_t   r_id_i,
  input  wire            r_last_i,
  output bus_pkg::word_t critical_word_o,
  output logic           critical_word_valid_o
);

  line_pkg::rd_state_e state_q;
  bus_pkg::len_t       beat_q;
  line_pkg::beat_idx_t beat_idx;
  logic                r_hs;

  assign ar_valid_o = (state_q == line_pkg::RD_ADDR);
  assign r_ready_o  = (state_q == line_pkg::RD_DATA);
  assign r_hs       = r_ready_o && r_valid_i;
  assign beat_idx   = line_pkg::beat_idx_t'(beat_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= line_pkg::RD_IDLE;
      beat_q  <= '0;
    end else begin
      case (state_q)
        line_pkg::RD_IDLE: begin
          if (cmd.rd_start) begin
            state_q <= line_pkg::RD_ADDR;
            beat_q  <= '0;
          end
        end
        line_pkg::RD_ADDR: begin
          if (ar_ready_i) begin
            state_q <= line_pkg::RD_DATA;
          end
        end
        line_pkg::RD_DATA: begin
          if (r_hs) begin
            beat_q <= beat_q + 1'b1;
            if (r_last_i) begin
              state_q <= line_pkg::RD_IDLE;
            end
          end
        end
        default: state_q <= line_pkg::RD_IDLE;
      endcase
    end
  end

  assign ar_addr_o = cmd.addr;
  assign ar_len_o  = cmd.len;
  assign ar_size_o = cmd.size;
  assign ar_id_o   = cmd.id;

  // ----------------------------------------
  // beat storage
  // ----------------------------------------
  assign lbuf.wr_en   = r_hs;
  assign lbuf.wr_idx  = beat_idx;
  assign lbuf.wr_word = r_data_i;

  // critical word only applies to line bursts
  assign critical_word_o       = r_data_i;
  assign critical_word_valid_o = r_hs && (cmd.len != '0) && (beat_idx == cmd.crit_idx);

  assign cmd.rd_done = r_hs && r_last_i;
  assign cmd.rd_id   = r_id_i;

endmodule

`default_nettype wire

//--- design/axi_line_adapter.sv
// Cache line to AXI adapter
`default_nettype none

module axi_line_adapter (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  // cache side
  input  wire                  req_i,
  input  wire                  we_i,
  input  line_pkg::req_kind_e  line_i,
  input  bus_pkg::addr_t       addr_i,
  input  bus_pkg::size_t       size_i,
  input  bus_pkg::id_t         id_i,
  input  line_pkg::line_t      wdata_i,
  input  line_pkg::line_strb_t be_i,
  output logic                 gnt_o,
  output logic                 valid_o,
  output line_pkg::line_t      rdata_o,
  output bus_pkg::id_t         id_o,
  output bus_pkg::word_t       critical_word_o,
  output logic                 critical_word_valid_o,
  // write address, data and response
  output logic                 aw_valid_o,
  input  wire                  aw_ready_i,
  output bus_pkg::addr_t       aw_addr_o,
  output bus_pkg::len_t        aw_len_o,
  output bus_pkg::size_t       aw_size_o,
  output bus_pkg::id_t         aw_id_o,
  output logic                 w_valid_o,
  input  wire                  w_ready_i,
  output bus_pkg::word_t       w_data_o,
  output bus_pkg::strb_t       w_strb_o,
  output logic                 w_last_o,
  input  wire                  b_valid_i,
  output logic                 b_ready_o,
  input  bus_pkg::id_t         b_id_i,
  // read address and data
  output logic                 ar_valid_o,
  input  wire                  ar_ready_i,
  output bus_pkg::addr_t       ar_addr_o,
  output bus_pkg::len_t        ar_len_o,
  output bus_pkg::size_t       ar_size_o,
  output bus_pkg::id_t         ar_id_o,
  input  wire                  r_valid_i,
  output logic                 r_ready_o,
  input  bus_pkg::word_t       r_data_i,
  input  bus_pkg::id_t         r_id_i,
  input  wire                  r_last_i
);

  line_buf_if  lbuf_bus ();
  burst_cmd_if cmd_bus ();

  request_ctrl u_ctrl (
    .clk_i, .rst_ni, .req_i, .we_i, .line_i, .addr_i, .size_i, .id_i,
    .wdata_i, .be_i, .gnt_o, .valid_o, .rdata_o, .id_o,
    .lbuf (lbuf_bus.ctrl_mp),
    .cmd  (cmd_bus.ctrl_mp)
  );

  line_buffer u_buf (.clk_i, .rst_ni, .bus (lbuf_bus.buf_mp));

  write_beat_issuer u_wr (
    .clk_i, .rst_ni,
    .cmd  (cmd_bus.wr_mp),
    .lbuf (lbuf_bus.issue_mp),
    .aw_valid_o, .aw_ready_i, .aw_addr_o, .aw_len_o, .aw_size_o, .aw_id_o,
    .w_valid_o, .w_ready_i, .w_data_o, .w_strb_o, .w_last_o,
    .b_valid_i, .b_ready_o, .b_id_i
  );

  read_beat_collector u_rd (
    .clk_i, .rst_ni,
    .cmd  (cmd_bus.rd_mp),
    .lbuf (lbuf_bus.collect_mp),
    .ar_valid_o, .ar_ready_i, .ar_addr_o, .ar_len_o, .ar_size_o, .ar_id_o,
    .r_valid_i, .r_ready_o, .r_data_i, .r_id_i, .r_last_i,
    .critical_word_o, .critical_word_valid_o
  );

endmodule

`default_nettype wire

//--- testbench/tb_clock_gen.sv
// Testbench clock and reset
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic rst_no
);

  localparam int HALF_PERIOD = 20;

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // reset held for two full cycles and released on a falling edge
  initial begin
    rst_no = 1'b0;
    #(4 * HALF_PERIOD);
    rst_no = 1'b1;
  end

endmodule

`default_nettype wire

//--- testbench/tb_axi_line_adapter.sv
// AXI line adapter testbench
`default_nettype none

`include "adapter_defs.svh"

module tb_axi_line_adapter;

  localparam int MAX_TRANS  = 40;
  localparam int MAX_CYCLES = MAX_TRANS * 64;
  localparam int ROUNDS     = 8;

  // one word per beat
  localparam bus_pkg::size_t WORD_SIZE = bus_pkg::size_t'($clog2(`ADP_WORD_W / 8));

  logic                 clk_i;
  logic                 rst_ni;
  logic                 req_i;
  logic                 we_i;
  line_pkg::req_kind_e  line_i;
  bus_pkg::addr_t       addr_i;
  bus_pkg::size_t       size_i;
  bus_pkg::id_t         id_i;
  line_pkg::line_t      wdata_i;
  line_pkg::line_strb_t be_i;
  logic                 gnt_o;
  logic                 valid_o;
  line_pkg::line_t      rdata_o;
  bus_pkg::id_t         id_o;
  bus_pkg::word_t       critical_word_o;
  logic                 critical_word_valid_o;
  logic                 aw_valid_o;
  logic                 aw_ready_i;
  bus_pkg::addr_t       aw_addr_o;
  bus_pkg::len_t        aw_len_o;
  bus_pkg::size_t       aw_size_o;
  bus_pkg::id_t         aw_id_o;
  logic                 w_valid_o;
  logic                 w_ready_i;
  bus_pkg::word_t       w_data_o;
  bus_pkg::strb_t       w_strb_o;
  logic                 w_last_o;
  logic                 b_valid_i;
  logic                 b_ready_o;
  bus_pkg::id_t         b_id_i;
  logic                 ar_valid_o;
  logic                 ar_ready_i;
  bus_pkg::addr_t       ar_addr_o;
  bus_pkg::len_t        ar_len_o;
  bus_pkg::size_t       ar_size_o;
  bus_pkg::id_t         ar_id_o;
  logic                 r_valid_i;
  logic                 r_ready_o;
  bus_pkg::word_t       r_data_i;
  bus_pkg::id_t         r_id_i;
  logic                 r_last_i;

  tb_clock_gen clk_gen0 (.clk_o (clk_i), .rst_no (rst_ni));

  axi_line_adapter dut0 (.*);

  // ----------------------------------------
  // error handling
  // ----------------------------------------
  task automatic halt_run();
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped");
  endtask

  task automatic flag_error(input string msg);
    $display("ERROR @%0t: %s", $time, msg);
    halt_run();
  endtask

  task automatic check_word(input bus_pkg::word_t got, input bus_pkg::word_t exp,
                            input string what);
    if (got !== exp) flag_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_line(input line_pkg::line_t got, input line_pkg::line_t exp,
                            input string what);
    if (got !== exp) flag_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_id(input bus_pkg::id_t got, input bus_pkg::id_t exp,
                          input string what);
    if (got !== exp) flag_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_addr(input bus_pkg::addr_t got, input bus_pkg::addr_t exp,
                            input string what);
    if (got !== exp) flag_error($sformatf("%s got %h expected %h", what, got, exp));
  endtask

  task automatic check_len(input bus_pkg::len_t got, input bus_pkg::len_t exp,
                           input string what);
    if (got !== exp) flag_error($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  task automatic check_size(input bus_pkg::size_t got, input bus_pkg::size_t exp,
                            input string what);
    if (got !== exp) flag_error($sformatf("%s got %0d expected %0d", what, got, exp));
  endtask

  // ----------------------------------------
  // reference model
  // ----------------------------------------
  bus_pkg::word_t shadow_mem [bus_pkg::addr_t];

  // initial memory content for a word address
  function automatic bus_pkg::word_t pattern_word(input bus_pkg::addr_t wa);
    return (wa * 32'h9e37_79b1) ^ {wa[15:0], wa[31:16]} ^ 32'h3c5a_0f96;
  endfunction

  function automatic bus_pkg::word_t merge_word(input bus_pkg::word_t old_w,
                                                input bus_pkg::word_t new_w,
                                                input bus_pkg::strb_t strb);
    bus_pkg::word_t res;
    res = old_w;
    for (int b = 0; b < `ADP_WORD_W / 8; b++) begin
      if (strb[b]) res[8*b +: 8] = new_w[8*b +: 8];
    end
    return res;
  endfunction

  function automatic bus_pkg::word_t expected_word(input bus_pkg::addr_t byte_addr);
    bus_pkg::addr_t key;
    key = byte_addr >> `ADP_WORD_OFS_W;
    if (shadow_mem.exists(key)) return shadow_mem[key];
    return pattern_word(key);
  endfunction

  function automatic line_pkg::line_t expected_line(input bus_pkg::addr_t base);
    line_pkg::line_t res;
    for (int i = 0; i < `ADP_LINE_WORDS; i++) begin
      res[i] = expected_word(base + bus_pkg::addr_t'(4 * i));
    end
    return res;
  endfunction

  task automatic store_word(input bus_pkg::addr_t byte_addr, input bus_pkg::word_t data,
                            input bus_pkg::strb_t strb);
    shadow_mem[byte_addr >> `ADP_WORD_OFS_W] = merge_word(expected_word(byte_addr), data, strb);
  endtask

  // ----------------------------------------
  // slave memory model
  // ----------------------------------------
  bus_pkg::word_t slave_mem [bus_pkg::addr_t];
  logic [31:0]    lfsr_q = 32'hb263;
  logic           aw_have;
  logic           w_have;
  logic           ar_have;
  logic           b_took;
  logic           r_took;
  bus_pkg::addr_t aw_addr_q;
  bus_pkg::addr_t ar_addr_q;
  bus_pkg::len_t  aw_len_q;
  bus_pkg::len_t  ar_len_q;
  bus_pkg::size_t aw_size_q;
  bus_pkg::size_t ar_size_q;
  bus_pkg::id_t   aw_id_q;
  bus_pkg::id_t   ar_id_q;
  bus_pkg::word_t w_data_q [$];
  bus_pkg::strb_t w_strb_q [$];
  logic           w_last_q [$];
  int             r_beat;

  // taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bit(output logic b);
    lfsr_q = lfsr_step(lfsr_q);
    b = lfsr_q[0];
  endtask

  function automatic bus_pkg::word_t slave_word(input bus_pkg::addr_t key);
    if (slave_mem.exists(key)) return slave_mem[key];
    return pattern_word(key);
  endfunction

  // apply a finished write burst to memory
  task automatic retire_write();
    bus_pkg::addr_t key;
    if (w_data_q.size() != int'(aw_len_q) + 1) begin
      flag_error($sformatf("write burst carried %0d W beats for len %0d",
                           w_data_q.size(), aw_len_q));
    end
    for (int i = 0; i < w_data_q.size(); i++) begin
      if (w_last_q[i] !== (i == int'(aw_len_q))) flag_error("w_last_o set on the wrong beat");
      key = (aw_addr_q >> `ADP_WORD_OFS_W) + bus_pkg::addr_t'(i);
      slave_mem[key] = merge_word(slave_word(key), w_data_q[i], w_strb_q[i]);
    end
    w_data_q.delete();
    w_strb_q.delete();
    w_last_q.delete();
    aw_have = 1'b0;
    w_have  = 1'b0;
  endtask

  // drive on the falling edge, then record what the next rising edge accepts
  initial begin
    aw_ready_i = 1'b0;
    w_ready_i  = 1'b0;
    b_valid_i  = 1'b0;
    b_id_i     = '0;
    ar_ready_i = 1'b0;
    r_valid_i  = 1'b0;
    r_data_i   = '0;
    r_id_i     = '0;
    r_last_i   = 1'b0;
    aw_have    = 1'b0;
    w_have     = 1'b0;
    ar_have    = 1'b0;
    b_took     = 1'b0;
    r_took     = 1'b0;
    r_beat     = 0;
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      if (b_took) b_valid_i = 1'b0;
      if (r_took) r_valid_i = 1'b0;
      take_bit(aw_ready_i);
      take_bit(w_ready_i);
      take_bit(ar_ready_i);
      if (!b_valid_i && aw_have && w_have) begin
        take_bit(b_valid_i);
        b_id_i = aw_id_q;
      end
      if (!r_valid_i && ar_have) begin
        take_bit(r_valid_i);
        r_data_i = slave_word((ar_addr_q >> `ADP_WORD_OFS_W) + bus_pkg::addr_t'(r_beat));
        r_id_i   = ar_id_q;
        r_last_i = (r_beat == int'(ar_len_q));
      end
      #1;
      b_took = b_valid_i && b_ready_o;
      r_took = r_valid_i && r_ready_o;
      if (aw_valid_o && aw_ready_i) begin
        aw_have   = 1'b1;
        aw_addr_q = aw_addr_o;
        aw_len_q  = aw_len_o;
        aw_size_q = aw_size_o;
        aw_id_q   = aw_id_o;
      end
      if (w_valid_o && w_ready_i) begin
        w_data_q.push_back(w_data_o);
        w_strb_q.push_back(w_strb_o);
        w_last_q.push_back(w_last_o);
        if (w_last_o) w_have = 1'b1;
      end
      if (b_took) retire_write();
      if (ar_valid_o && ar_ready_i) begin
        ar_have   = 1'b1;
        ar_addr_q = ar_addr_o;
        ar_len_q  = ar_len_o;
        ar_size_q = ar_size_o;
        ar_id_q   = ar_id_o;
        r_beat    = 0;
      end
      if (r_took) begin
        r_beat++;
        if (r_last_i) ar_have = 1'b0;
      end
    end
  end

  // ----------------------------------------
  // stimulus
  // ----------------------------------------
  line_pkg::line_t got_line;
  bus_pkg::id_t    got_id;
  bus_pkg::word_t  got_crit;
  int              crit_cnt;

  task automatic run_request(input logic we, input line_pkg::req_kind_e kind,
                             input bus_pkg::addr_t addr, input line_pkg::line_t wdata,
                             input line_pkg::line_strb_t be, input bus_pkg::id_t id);
    @(negedge clk_i);
    req_i   = 1'b1;
    we_i    = we;
    line_i  = kind;
    addr_i  = addr;
    size_i  = WORD_SIZE;
    id_i    = id;
    wdata_i = wdata;
    be_i    = be;
    #1;
    if (valid_o !== 1'b0) flag_error("valid_o still high when a new request starts");
    if (gnt_o !== 1'b1) flag_error("request not granted while the adapter is idle");
    @(negedge clk_i);
    // write data was copied on the grant
    req_i    = 1'b0;
    wdata_i  = '0;
    be_i     = '0;
    crit_cnt = 0;
    #1;
    forever begin
      if (gnt_o !== 1'b0) flag_error("second grant for a single request");
      if (critical_word_valid_o === 1'b1) begin
        crit_cnt++;
        got_crit = critical_word_o;
      end
      if (valid_o === 1'b1) break;
      @(negedge clk_i);
      #1;
    end
    got_line = rdata_o;
    got_id   = id_o;
  endtask

  task automatic expect_crit_flags(input int n);
    if (crit_cnt != n) begin
      flag_error($sformatf("critical word flagged %0d times, expected %0d", crit_cnt, n));
    end
  endtask

  initial begin
    bus_pkg::addr_t       base;
    bus_pkg::addr_t       addr;
    line_pkg::line_t      wline;
    line_pkg::line_strb_t wbe;
    bus_pkg::id_t         id;
    int                   crit;
    req_i   = 1'b0;
    we_i    = 1'b0;
    line_i  = line_pkg::REQ_SINGLE;
    addr_i  = '0;
    size_i  = '0;
    id_i    = '0;
    wdata_i = '0;
    be_i    = '0;
    wait (rst_ni === 1'b1);
    @(negedge clk_i);
    #1;
    if ({gnt_o, valid_o, critical_word_valid_o, aw_valid_o, w_valid_o, ar_valid_o,
         b_ready_o, r_ready_o} !== '0) begin
      flag_error("handshake outputs not low after reset");
    end
    for (int r = 0; r < ROUNDS; r++) begin
      base = pattern_word(bus_pkg::addr_t'(r)) & 32'h000f_ffc0;
      // single write and read back
      addr = base + bus_pkg::addr_t'(4 * (r % 4));
      wline    = '0;
      wbe      = '0;
      wline[0] = pattern_word(addr ^ 32'h5555_0000);
      wline[1] = ~wline[0];
      wbe[0]   = (r == 0) ? 4'hf : bus_pkg::strb_t'(r + 1);
      wbe[1]   = 4'hf;
      id = bus_pkg::id_t'(4 * r);
      run_request(1'b1, line_pkg::REQ_SINGLE, addr, wline, wbe, id);
      store_word(addr, wline[0], wbe[0]);
      check_id(got_id, id, "single write id");
      check_addr(aw_addr_q, addr, "single write AW address");
      check_len(aw_len_q, '0, "single write AW len");
      check_size(aw_size_q, WORD_SIZE, "single write AW size");
      expect_crit_flags(0);
      run_request(1'b0, line_pkg::REQ_SINGLE, addr, '0, '0, bus_pkg::id_t'(id + 1));
      check_word(got_line[0], expected_word(addr), "single read data");
      check_id(got_id, bus_pkg::id_t'(id + 1), "single read id");
      check_addr(ar_addr_q, addr, "single read AR address");
      check_len(ar_len_q, '0, "single read AR len");
      check_size(ar_size_q, WORD_SIZE, "single read AR size");
      expect_crit_flags(0);
      // line write from an unaligned address and a line read
      base = base + 32'h10;
      for (int i = 0; i < `ADP_LINE_WORDS; i++) begin
        wline[i] = pattern_word(base + bus_pkg::addr_t'(i + 32'h900 * r));
        wbe[i]   = (r % 2 == 0) ? 4'hf : bus_pkg::strb_t'(4'hf >> i);
      end
      run_request(1'b1, line_pkg::REQ_LINE, base + 32'h9, wline, wbe, bus_pkg::id_t'(id + 2));
      for (int i = 0; i < `ADP_LINE_WORDS; i++) begin
        store_word(base + bus_pkg::addr_t'(4 * i), wline[i], wbe[i]);
      end
      check_id(got_id, bus_pkg::id_t'(id + 2), "line write id");
      check_addr(aw_addr_q, base, "line write AW address");
      check_len(aw_len_q, bus_pkg::len_t'(`ADP_LINE_WORDS - 1), "line write AW len");
      check_size(aw_size_q, WORD_SIZE, "line write AW size");
      expect_crit_flags(0);
      crit = (r + 3) % `ADP_LINE_WORDS;
      run_request(1'b0, line_pkg::REQ_LINE, base + bus_pkg::addr_t'(4 * crit), '0, '0,
                  bus_pkg::id_t'(id + 3));
      check_line(got_line, expected_line(base), "line read data");
      check_id(got_id, bus_pkg::id_t'(id + 3), "line read id");
      check_addr(ar_addr_q, base, "line read AR address");
      check_len(ar_len_q, bus_pkg::len_t'(`ADP_LINE_WORDS - 1), "line read AR len");
      check_size(ar_size_q, WORD_SIZE, "line read AR size");
      expect_crit_flags(1);
      check_word(got_crit, expected_word(base + bus_pkg::addr_t'(4 * crit)), "critical word");
    end
    // untouched memory returns the initial pattern
    run_request(1'b0, line_pkg::REQ_LINE, 32'h00f0_0008, '0, '0, 4'h7);
    check_line(got_line, expected_line(32'h00f0_0000), "untouched line data");
    expect_crit_flags(1);
    check_word(got_crit, expected_word(32'h00f0_0008), "untouched critical word");
    run_request(1'b0, line_pkg::REQ_SINGLE, 32'h00f0_1004, '0, '0, 4'hc);
    check_word(got_line[0], expected_word(32'h00f0_1004), "untouched single data");
    check_id(got_id, 4'hc, "untouched single id");
    @(negedge clk_i);
    #1;
    if (valid_o !== 1'b0) begin
      flag_error("valid_o high for more than one cycle");
    end else begin
      $display("RESULT: PASS");
      $finish;
    end
  end

  // ----------------------------------------
  // timeout
  // ----------------------------------------
  int unsigned cycle_cnt = 0;

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      halt_run();
    end
  end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
design/bus_pkg.sv
design/line_pkg.sv
design/line_buf_if.sv
design/burst_cmd_if.sv
design/line_buffer.sv
design/request_ctrl.sv
design/write_beat_issuer.sv
design/read_beat_collector.sv
design/axi_line_adapter.sv
testbench/tb_clock_gen.sv
testbench/tb_axi_line_adapter.sv
